/* hw/load_ctrl_fsm.sv */
// ----------------------------------------------------------
// load control FSM
// issues cache requests, retries tlb misses, kills on flush
// ----------------------------------------------------------

module load_ctrl_fsm (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // request from issue
    input  logic                    valid_i,
    input  load_unit_pkg::load_req_t load_req_i,
    // translation and store checker results
    input  logic                    dtlb_hit_i,
    input  logic                    page_offset_matches_i,
    // cache handshake inputs
    input  logic                    data_gnt_i,
    input  logic                    data_rvalid_i,
    // control outputs
    output logic                    pop_ld_o,
    output logic                    translation_req_o,
    output logic                    data_req_o,
    output logic                    kill_req_o,
    output logic                    tag_valid_o,
    // retire towards writeback
    output logic                    valid_o,
    output load_unit_pkg::trans_id_t trans_id_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_PAGE_OFFSET,
        WAIT_GNT,
        SEND_TAG,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } load_state_e;

    load_state_e state_d, state_q;

    // set in the states that may take a fresh request from issue
    logic accept_new;

    // id of the load whose data is expected next
    load_unit_pkg::trans_id_t trans_id_q;

    // ----------------------------------------------------------
    // next state and cache control
    // ----------------------------------------------------------

    always_comb begin
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        kill_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        pop_ld_o          = 1'b0;
        accept_new        = 1'b0;

        unique case (state_q)
            IDLE: begin
                accept_new = 1'b1;
            end

            // a pending store touches the same page offset so hold off
            // the cache request until the store checker clears
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // keep both the translation and the cache request up until
            // the arbiter grants us
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
            end

            // the tag for the granted index goes out here
            // the next load can already be started in this cycle
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                accept_new  = 1'b1;
            end

            // the translation missed after the grant so the cache slot is
            // released with a kill instead of a tag
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end

            // give the page table walker time and retry once the tlb hits
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // cancel whatever is outstanding at the cache after a flush
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // new request from issue
        // the translation is started early even if the offset check
        // may still stall us, which keeps the mmu path short
        if (accept_new && valid_i) begin
            translation_req_o = 1'b1;
            if (page_offset_matches_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req_o = 1'b1;
                // without a grant this becomes a wait, overridden below
                state_d    = WAIT_GNT;
            end
        end

        // a granted request either proceeds to the tag cycle or has to
        // be aborted because the physical address is not known yet
        if (data_req_o && data_gnt_i) begin
            if (dtlb_hit_i) begin
                state_d  = SEND_TAG;
                pop_ld_o = 1'b1;
            end else begin
                state_d = ABORT_TRANSACTION;
            end
        end

        // flush wins over everything else
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // ----------------------------------------------------------
    // retire
    // ----------------------------------------------------------

    // returned data is dropped while a kill is on the port or the unit
    // is flushing, since it belongs to a cancelled load
    assign valid_o = data_rvalid_i && (state_q != WAIT_FLUSH) && !kill_req_o;

    assign trans_id_o = trans_id_q;

    // ----------------------------------------------------------
    // registers
    // ----------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the id follows the request that was last handed to the cache
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trans_id_q <= '0;
        end else if (pop_ld_o) begin
            trans_id_q <= load_req_i.trans_id;
        end
    end

endmodule

/* hw/load_result_align.sv */
// ----------------------------------------------------------
// load result aligner
// shifts the cache word by the byte offset and extends it
// ----------------------------------------------------------

module load_result_align (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // capture strobe from the control FSM
    input  logic                        pop_i,
    input  load_unit_pkg::load_op_t     op_i,
    input  load_unit_pkg::byte_offset_t offset_i,
    // raw word from the cache
    input  load_unit_pkg::xlen_t        rdata_i,
    output load_unit_pkg::xlen_t        result_o
);

    // operation captured at issue
    load_unit_pkg::load_op_t     op_q;
    load_unit_pkg::byte_offset_t offset_q;
    // precomputed sign selection
    logic                        signed_d, signed_q;
    load_unit_pkg::byte_offset_t idx_d, idx_q;

    load_unit_pkg::xlen_t                 shifted_data;
    logic [load_unit_pkg::XLEN/8-1:0]     sign_bits;
    logic                                 sign_bit;

    // ----------------------------------------------------------
    // capture at pop
    // ----------------------------------------------------------

    // only the signed variants pull in the sign bit
    assign signed_d = op_i inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};

    // the sign lives in the top byte of the loaded item
    // which is three bytes above the offset for a word and one for a half
    always_comb begin
        if (op_i inside {load_unit_pkg::LW, load_unit_pkg::LWU}) begin
            idx_d = offset_i + 3'd3;
        end else if (op_i inside {load_unit_pkg::LH, load_unit_pkg::LHU}) begin
            idx_d = offset_i + 3'd1;
        end else begin
            idx_d = offset_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_q     <= load_unit_pkg::LD;
            offset_q <= '0;
            signed_q <= 1'b0;
            idx_q    <= '0;
        end else if (pop_i) begin
            op_q     <= op_i;
            offset_q <= offset_i;
            signed_q <= signed_d;
            idx_q    <= idx_d;
        end
    end

    // ----------------------------------------------------------
    // realign and extend
    // ----------------------------------------------------------

    // move the addressed byte down to bit 0
    assign shifted_data = rdata_i >> {offset_q, 3'b000};

    // msb of every byte lane, so the sign can be picked without waiting
    // for the shifter
    always_comb begin
        for (int unsigned i = 0; i < load_unit_pkg::XLEN / 8; i++) begin
            sign_bits[i] = rdata_i[8*i+7];
        end
    end

    // unsigned loads always extend with zeros
    assign sign_bit = signed_q & sign_bits[idx_q];

    always_comb begin
        unique case (op_q)
            load_unit_pkg::LW, load_unit_pkg::LWU: begin
                result_o = {{(load_unit_pkg::XLEN - 32){sign_bit}}, shifted_data[31:0]};
            end
            load_unit_pkg::LH, load_unit_pkg::LHU: begin
                result_o = {{(load_unit_pkg::XLEN - 16){sign_bit}}, shifted_data[15:0]};
            end
            load_unit_pkg::LB, load_unit_pkg::LBU: begin
                result_o = {{(load_unit_pkg::XLEN - 8){sign_bit}}, shifted_data[7:0]};
            end
            default: begin
                result_o = shifted_data;
            end
        endcase
    end

endmodule

/* hw/load_unit.sv */
// ----------------------------------------------------------
// load unit
// load path between issue, mmu, data cache and writeback
// ----------------------------------------------------------

module load_unit (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    // issue port
    input  logic                          valid_i,
    input  load_unit_pkg::load_req_t      load_req_i,
    output logic                          pop_ld_o,
    // address translation
    output logic                          translation_req_o,
    output load_unit_pkg::vaddr_t         vaddr_o,
    input  load_unit_pkg::paddr_t         paddr_i,
    input  logic                          dtlb_hit_i,
    // store address checker
    output load_unit_pkg::page_offset_t   page_offset_o,
    input  logic                          page_offset_matches_i,
    // data cache port
    input  load_unit_pkg::dcache_rsp_t    dcache_rsp_i,
    output load_unit_pkg::dcache_req_t    dcache_req_o,
    // writeback
    output logic                          valid_o,
    output load_unit_pkg::trans_id_t      trans_id_o,
    output load_unit_pkg::xlen_t          result_o
);

    logic       pop;
    logic       data_req;
    logic       kill_req;
    logic       tag_valid;
    logic [1:0] data_size;

    // ----------------------------------------------------------
    // address feed-through
    // ----------------------------------------------------------

    // the mmu and the store checker both look at the untranslated request
    assign vaddr_o       = load_req_i.vaddr;
    assign page_offset_o = load_req_i.vaddr[11:0];

    // the index comes straight from the page offset, the tag from the
    // translation that arrives in the same cycle as the hit
    assign dcache_req_o.address_index =
        load_req_i.vaddr[load_unit_pkg::DCACHE_INDEX_WIDTH-1:0];
    assign dcache_req_o.address_tag =
        paddr_i[load_unit_pkg::DCACHE_TAG_WIDTH + load_unit_pkg::DCACHE_INDEX_WIDTH - 1 :
                load_unit_pkg::DCACHE_INDEX_WIDTH];
    assign dcache_req_o.data_be = load_req_i.be;

    // transfer size as log2 of the byte count
    always_comb begin
        unique case (load_req_i.op)
            load_unit_pkg::LW, load_unit_pkg::LWU: data_size = 2'b10;
            load_unit_pkg::LH, load_unit_pkg::LHU: data_size = 2'b01;
            load_unit_pkg::LB, load_unit_pkg::LBU: data_size = 2'b00;
            default:                               data_size = 2'b11;
        endcase
    end

    assign dcache_req_o.data_size = data_size;

    // control fields come from the FSM
    assign dcache_req_o.data_req  = data_req;
    assign dcache_req_o.kill_req  = kill_req;
    assign dcache_req_o.tag_valid = tag_valid;

    assign pop_ld_o = pop;

    // ----------------------------------------------------------
    // submodules
    // ----------------------------------------------------------

    load_ctrl_fsm i_load_ctrl_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_req_i            (load_req_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .data_gnt_i            (dcache_rsp_i.data_gnt),
        .data_rvalid_i         (dcache_rsp_i.data_rvalid),
        .pop_ld_o              (pop),
        .translation_req_o     (translation_req_o),
        .data_req_o            (data_req),
        .kill_req_o            (kill_req),
        .tag_valid_o           (tag_valid),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o)
    );

    load_result_align i_load_result_align (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pop_i    (pop),
        .op_i     (load_req_i.op),
        .offset_i (load_req_i.vaddr[2:0]),
        .rdata_i  (dcache_rsp_i.data_rdata),
        .result_o (result_o)
    );

endmodule

/* hw/load_unit_pkg.sv */
// ----------------------------------------------------------
// load unit package
// shared widths, vector types, load codes and port structs
// ----------------------------------------------------------

package load_unit_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------

    // data path width of the integer pipeline
    localparam int unsigned XLEN = 64;
    // sv39 virtual address width
    localparam int unsigned VLEN = 39;
    // physical address width as delivered by the mmu
    localparam int unsigned PLEN = 56;
    // scoreboard entries are tracked with this many id bits
    localparam int unsigned TRANS_ID_BITS = 3;
    // the index covers the untranslated page offset
    localparam int unsigned DCACHE_INDEX_WIDTH = 12;
    // the tag holds the remaining physical address bits
    localparam int unsigned DCACHE_TAG_WIDTH = 44;

    // ----------------------------------------------------------
    // vector types
    // ----------------------------------------------------------

    typedef logic [XLEN-1:0]               xlen_t;
    typedef logic [VLEN-1:0]               vaddr_t;
    typedef logic [PLEN-1:0]               paddr_t;
    typedef logic [TRANS_ID_BITS-1:0]      trans_id_t;
    // the lower 12 bits are identical in the virtual and physical address
    typedef logic [11:0]                   page_offset_t;
    // position of the first byte within a 64-bit word
    typedef logic [2:0]                    byte_offset_t;
    typedef logic [DCACHE_INDEX_WIDTH-1:0] dcache_index_t;
    typedef logic [DCACHE_TAG_WIDTH-1:0]   dcache_tag_t;
    typedef logic [3:0]                    load_op_t;

    // ----------------------------------------------------------
    // load operation codes
    // ----------------------------------------------------------

    // full doubleword, no extension needed
    localparam load_op_t LD  = 4'd0;
    // word loads, signed and unsigned
    localparam load_op_t LW  = 4'd1;
    localparam load_op_t LWU = 4'd2;
    // halfword loads
    localparam load_op_t LH  = 4'd3;
    localparam load_op_t LHU = 4'd4;
    // byte loads
    localparam load_op_t LB  = 4'd5;
    localparam load_op_t LBU = 4'd6;

    // ----------------------------------------------------------
    // port structs
    // ----------------------------------------------------------

    // load request as handed over from the issue stage
    typedef struct packed {
        trans_id_t  trans_id;
        vaddr_t     vaddr;
        load_op_t   op;
        logic [7:0] be;
    } load_req_t;

    // request towards the data cache
    // the index goes out first and the tag follows after the grant
    typedef struct packed {
        dcache_index_t address_index;
        dcache_tag_t   address_tag;
        logic          data_req;
        logic [7:0]    data_be;
        logic [1:0]    data_size;
        logic          kill_req;
        logic          tag_valid;
    } dcache_req_t;

    // response from the data cache
    typedef struct packed {
        logic  data_gnt;
        logic  data_rvalid;
        xlen_t data_rdata;
    } dcache_rsp_t;

endpackage

/* load_unit.f */
hw/load_unit_pkg.sv
hw/load_ctrl_fsm.sv
hw/load_result_align.sv
hw/load_unit.sv
test/dcache_model.sv
test/tb_load_unit.sv

/* test/dcache_model.sv */
// ----------------------------------------------------------
// data cache model
// grants after a set delay, takes tags and returns read data
// ----------------------------------------------------------

module dcache_model (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  load_unit_pkg::dcache_req_t req_i,
    // number of request cycles before a grant is given
    input  logic [3:0]                 gnt_delay_i,
    output load_unit_pkg::dcache_rsp_t rsp_o,
    // tags that started a read and tags that were killed
    output logic [7:0]                 tag_count_o,
    output logic [7:0]                 kill_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0]                   wait_q;
    logic                         tag_pending_q;
    load_unit_pkg::dcache_index_t index_q;
    logic                         rvalid_q;
    load_unit_pkg::xlen_t         rdata_q;
    logic                         gnt;

    // contents of the word at a doubleword address
    // the odd multiplier makes every address bit reach the data
    function automatic load_unit_pkg::xlen_t mem_word(logic [52:0] waddr);
        load_unit_pkg::xlen_t h;
        h = {11'h0, waddr} * 64'h9E37_79B9_7F4A_7C15;
        return h ^ (h >> 29);
    endfunction

    // only one index can wait for its tag at a time
    assign gnt = req_i.data_req && !tag_pending_q && (wait_q >= gnt_delay_i);

    assign rsp_o.data_gnt    = gnt;
    assign rsp_o.data_rvalid = rvalid_q;
    assign rsp_o.data_rdata  = rdata_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q        <= '0;
            tag_pending_q <= 1'b0;
            index_q       <= '0;
            rvalid_q      <= 1'b0;
            rdata_q       <= '0;
            tag_count_o   <= '0;
            kill_count_o  <= '0;
        end else begin
            rvalid_q <= 1'b0;
            // count the cycles a request waits for the arbiter
            if (gnt) begin
                wait_q        <= '0;
                tag_pending_q <= 1'b1;
                index_q       <= req_i.address_index;
            end else if (req_i.data_req && wait_q != 4'hf) begin
                wait_q <= wait_q + 4'd1;
            end
            // the tag cycle either starts the read or drops it
            if (tag_pending_q && req_i.tag_valid) begin
                tag_pending_q <= 1'b0;
                if (req_i.kill_req) begin
                    kill_count_o <= kill_count_o + 8'd1;
                end else begin
                    tag_count_o <= tag_count_o + 8'd1;
                    rvalid_q    <= 1'b1;
                    rdata_q     <= mem_word({req_i.address_tag, index_q[11:3]});
                end
            end
        end
    end

endmodule

/* test/tb_load_unit.sv */
// ----------------------------------------------------------
// load unit testbench
// directed tests of issue, stalls, tlb retry, flush and retire
// ----------------------------------------------------------

module tb_load_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned TIMEOUT = 100;
    localparam logic [31:0] SEED    = 32'd74970;
    // every load goes to this physical page
    localparam logic [43:0] PAGE    = 44'h123_4567_89AB;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         flush_i;
    logic                         valid_i;
    load_unit_pkg::load_req_t     load_req;
    logic                         pop_ld;
    logic                         translation_req;
    load_unit_pkg::vaddr_t        vaddr;
    load_unit_pkg::paddr_t        paddr;
    logic                         dtlb_hit;
    load_unit_pkg::page_offset_t  page_offset;
    logic                         page_offset_matches;
    load_unit_pkg::dcache_rsp_t   dcache_rsp;
    load_unit_pkg::dcache_req_t   dcache_req;
    logic                         valid_o;
    load_unit_pkg::trans_id_t     trans_id;
    load_unit_pkg::xlen_t         result;
    logic [3:0]                   gnt_delay;
    logic [7:0]                   tag_count;
    logic [7:0]                   kill_count;
    logic [31:0]                  lfsr_q;

    // the mmu maps the page offset through unchanged
    assign paddr = {PAGE, load_req.vaddr[11:0]};

    load_unit i_dut (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_req_i            (load_req),
        .pop_ld_o              (pop_ld),
        .translation_req_o     (translation_req),
        .vaddr_o               (vaddr),
        .paddr_i               (paddr),
        .dtlb_hit_i            (dtlb_hit),
        .page_offset_o         (page_offset),
        .page_offset_matches_i (page_offset_matches),
        .dcache_rsp_i          (dcache_rsp),
        .dcache_req_o          (dcache_req),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id),
        .result_o              (result)
    );

    dcache_model i_dcache (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (dcache_req),
        .gnt_delay_i  (gnt_delay),
        .rsp_o        (dcache_rsp),
        .tag_count_o  (tag_count),
        .kill_count_o (kill_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step for every bit handed out
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // same memory contents as the cache model
    function automatic load_unit_pkg::xlen_t mem_word(logic [52:0] waddr);
        load_unit_pkg::xlen_t h;
        h = {11'h0, waddr} * 64'h9E37_79B9_7F4A_7C15;
        return h ^ (h >> 29);
    endfunction

    function automatic int op_bytes(load_unit_pkg::load_op_t op);
        case (op)
            load_unit_pkg::LW, load_unit_pkg::LWU: return 4;
            load_unit_pkg::LH, load_unit_pkg::LHU: return 2;
            load_unit_pkg::LB, load_unit_pkg::LBU: return 1;
            default: return 8;
        endcase
    endfunction

    // the loaded item sits at the offset and is extended by its own top bit
    function automatic load_unit_pkg::xlen_t expected_result(load_unit_pkg::load_req_t req);
        load_unit_pkg::paddr_t pa;
        load_unit_pkg::xlen_t  sh;
        pa = {PAGE, req.vaddr[11:0]};
        sh = mem_word(pa[55:3]) >> (8 * pa[2:0]);
        case (req.op)
            load_unit_pkg::LW:  return {{32{sh[31]}}, sh[31:0]};
            load_unit_pkg::LWU: return {32'h0, sh[31:0]};
            load_unit_pkg::LH:  return {{48{sh[15]}}, sh[15:0]};
            load_unit_pkg::LHU: return {48'h0, sh[15:0]};
            load_unit_pkg::LB:  return {{56{sh[7]}}, sh[7:0]};
            load_unit_pkg::LBU: return {56'h0, sh[7:0]};
            default:            return sh;
        endcase
    endfunction

    function automatic load_unit_pkg::load_req_t make_req(load_unit_pkg::load_op_t op,
                                                          logic [2:0] off, logic [2:0] id);
        load_unit_pkg::load_req_t req;
        logic [26:0]              upper_bits;
        logic [8:0]               line_bits;
        upper_bits   = 27'(rand_bits(27));
        line_bits    = 9'(rand_bits(9));
        req.trans_id = id;
        req.op       = op;
        req.vaddr    = {upper_bits, line_bits, off};
        req.be       = 8'((16'h1 << op_bytes(op)) - 1) << off;
        return req;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(string name, load_unit_pkg::xlen_t got, load_unit_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // ----------------------------------------------------------
    // load sequence pieces, all entered just after a falling edge
    // ----------------------------------------------------------

    // waits for the pop and returns the number of stalled request cycles
    task automatic wait_pop(output int stalls);
        int n;
        n      = 0;
        stalls = 0;
        forever begin
            @(posedge clk_i);
            if (pop_ld) begin
                check("data_req", dcache_req.data_req, 1);
                break;
            end
            if (dcache_req.data_req) begin
                check("translation_req_o", translation_req, 1);
                stalls++;
            end
            n++;
            if (n > TIMEOUT) fail_run("timeout while waiting for the load to be popped");
            @(negedge clk_i);
        end
    endtask

    task automatic wait_retire(load_unit_pkg::load_req_t req);
        int n;
        n = 0;
        forever begin
            @(posedge clk_i);
            if (valid_o) begin
                check("trans_id_o", trans_id, req.trans_id);
                check("result_o", result, expected_result(req));
                break;
            end
            n++;
            if (n > TIMEOUT) fail_run("timeout while waiting for the load result");
            @(negedge clk_i);
        end
        @(negedge clk_i);
    endtask

    // tag one cycle after the grant, then the result
    task automatic finish_load(load_unit_pkg::load_req_t req);
        @(negedge clk_i);
        valid_i = 1'b0;
        @(posedge clk_i);
        check("tag_valid", dcache_req.tag_valid, 1);
        check("kill_req", dcache_req.kill_req, 0);
        @(negedge clk_i);
        wait_retire(req);
    endtask

    task automatic load_once(load_unit_pkg::load_req_t req, output int stalls);
        valid_i  = 1'b1;
        load_req = req;
        wait_pop(stalls);
        // address and transfer fields as seen in the granted cycle
        check("vaddr_o", vaddr, req.vaddr);
        check("data_be", dcache_req.data_be, req.be);
        check("data_size", dcache_req.data_size, $clog2(op_bytes(req.op)));
        finish_load(req);
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------

    task automatic test_all_ops();
        load_unit_pkg::load_op_t ops[7];
        int stalls;
        ops = '{load_unit_pkg::LD, load_unit_pkg::LW, load_unit_pkg::LWU, load_unit_pkg::LH,
                load_unit_pkg::LHU, load_unit_pkg::LB, load_unit_pkg::LBU};
        foreach (ops[i]) begin
            for (int off = 0; off < 8; off += op_bytes(ops[i])) begin
                gnt_delay = 4'(rand_bits(2));
                load_once(make_req(ops[i], 3'(off), 3'(rand_bits(3))), stalls);
            end
        end
    endtask

    task automatic test_gnt_stall();
        int stalls;
        gnt_delay = 4'd6;
        load_once(make_req(load_unit_pkg::LD, 3'd0, 3'd2), stalls);
        check("stall_cycles", stalls, 6);
    endtask

    task automatic test_tlb_miss();
        load_unit_pkg::load_req_t req;
        logic [7:0] kills;
        logic [7:0] tags;
        int n;
        int stalls;
        req       = make_req(load_unit_pkg::LH, 3'd6, 3'd5);
        kills     = kill_count;
        tags      = tag_count;
        gnt_delay = 4'd1;
        dtlb_hit  = 1'b0;
        valid_i   = 1'b1;
        load_req  = req;
        n         = 0;
        // the grant without a hit turns into a kill in the next cycle
        forever begin
            @(posedge clk_i);
            check("pop_ld_o", pop_ld, 0);
            if (dcache_req.kill_req && dcache_req.tag_valid) break;
            n++;
            if (n > TIMEOUT) fail_run("no kill seen after the tlb miss");
            @(negedge clk_i);
        end
        repeat (3) @(negedge clk_i);
        dtlb_hit = 1'b1;
        wait_pop(stalls);
        finish_load(req);
        check("killed_tags", kill_count - kills, 1);
        // only the retried request may start a read
        check("read_tags", tag_count - tags, 1);
    endtask

    task automatic test_page_offset();
        load_unit_pkg::load_req_t req;
        int stalls;
        req                 = make_req(load_unit_pkg::LBU, 3'd3, 3'd1);
        gnt_delay           = 4'd0;
        page_offset_matches = 1'b1;
        valid_i             = 1'b1;
        load_req            = req;
        repeat (5) begin
            @(posedge clk_i);
            check("data_req", dcache_req.data_req, 0);
            check("pop_ld_o", pop_ld, 0);
            check("page_offset_o", page_offset, req.vaddr[11:0]);
            @(negedge clk_i);
        end
        page_offset_matches = 1'b0;
        wait_pop(stalls);
        finish_load(req);
    endtask

    task automatic test_flush();
        int stalls;
        gnt_delay = 4'd2;
        valid_i   = 1'b1;
        load_req  = make_req(load_unit_pkg::LW, 3'd4, 3'd3);
        wait_pop(stalls);
        @(negedge clk_i);
        valid_i = 1'b0;
        flush_i = 1'b1;
        @(posedge clk_i);
        check("tag_valid", dcache_req.tag_valid, 1);
        @(negedge clk_i);
        flush_i = 1'b0;
        // the read data comes back here but belongs to the flushed load
        @(posedge clk_i);
        check("kill_req", dcache_req.kill_req, 1);
        check("tag_valid", dcache_req.tag_valid, 1);
        check("data_rvalid", dcache_rsp.data_rvalid, 1);
        check("valid_o", valid_o, 0);
        repeat (8) begin
            @(negedge clk_i);
            @(posedge clk_i);
            check("valid_o", valid_o, 0);
        end
        @(negedge clk_i);
        load_once(make_req(load_unit_pkg::LD, 3'd0, 3'd4), stalls);
    endtask

    task automatic test_back_to_back();
        load_unit_pkg::load_req_t reqs[2];
        int stalls;
        int retired;
        int n;
        reqs[0]   = make_req(load_unit_pkg::LB, 3'd7, 3'd6);
        reqs[1]   = make_req(load_unit_pkg::LHU, 3'd2, 3'd7);
        gnt_delay = 4'd0;
        valid_i   = 1'b1;
        load_req  = reqs[0];
        wait_pop(stalls);
        @(negedge clk_i);
        load_req = reqs[1];
        // the second request is already presented in the tag cycle
        @(posedge clk_i);
        check("tag_valid", dcache_req.tag_valid, 1);
        check("data_req", dcache_req.data_req, 1);
        check("translation_req_o", translation_req, 1);
        retired = 0;
        n       = 0;
        forever begin
            @(negedge clk_i);
            @(posedge clk_i);
            if (valid_o) begin
                check("trans_id_o", trans_id, reqs[retired].trans_id);
                check("result_o", result, expected_result(reqs[retired]));
                retired++;
            end
            if (pop_ld) begin
                @(negedge clk_i);
                valid_i = 1'b0;
                @(posedge clk_i);
                check("tag_valid", dcache_req.tag_valid, 1);
            end
            if (retired == 2) break;
            n++;
            if (n > TIMEOUT) fail_run("back-to-back loads did not both retire");
        end
        @(negedge clk_i);
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------

    initial begin
        lfsr_q              = SEED;
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        valid_i             = 1'b0;
        load_req            = '0;
        dtlb_hit            = 1'b1;
        page_offset_matches = 1'b0;
        gnt_delay           = 4'd0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;
        @(posedge clk_i);
        check("pop_ld_o", pop_ld, 0);
        check("translation_req_o", translation_req, 0);
        check("data_req", dcache_req.data_req, 0);
        check("kill_req", dcache_req.kill_req, 0);
        check("tag_valid", dcache_req.tag_valid, 0);
        check("valid_o", valid_o, 0);
        @(negedge clk_i);
        test_all_ops();
        test_gnt_stall();
        test_tlb_miss();
        test_page_offset();
        test_flush();
        test_back_to_back();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
